// File: hw/s16_main_pkg.sv
package s16_main_pkg;

    localparam int DATA_W = 16;
    localparam int BYTE_W = 8;

    // CPU word address, byte address bits 23:1
    typedef union packed {
        // Memory-map fields
        struct packed {
            logic [1:0]  area;
            logic [2:0]  spare;
            logic [2:0]  page;
            logic [14:0] offset;
        } region;
        // I/O register fields
        struct packed {
            logic [9:0]  spare_hi;
            logic [1:0]  io_port;
            logic [8:0]  spare_lo;
            logic [1:0]  io_reg;
        } io;
    } s16_addr_t;

    // Top two address bits
    localparam logic [1:0] AREA_ROM = 2'd0;
    localparam logic [1:0] AREA_VID = 2'd1;
    localparam logic [1:0] AREA_PAL = 2'd2;
    localparam logic [1:0] AREA_SYS = 2'd3;

    // Address bits 18:16 inside an area
    localparam logic [2:0] PAGE_VRAM = 3'd0;
    localparam logic [2:0] PAGE_CHAR = 3'd1;
    localparam logic [2:0] PAGE_OBJ  = 3'd4;
    localparam logic [2:0] PAGE_PAL  = 3'd4;
    localparam logic [2:0] PAGE_IO   = 3'd4;
    localparam logic [2:0] PAGE_RAM  = 3'd7;

    // Address bits 13:12 inside the I/O page
    localparam logic [1:0] IO_PPI = 2'd0;
    localparam logic [1:0] IO_CAB = 2'd1;
    localparam logic [1:0] IO_DIP = 2'd2;

endpackage

// File: hw/s16_cpu_bus_if.sv
`timescale 1ns/1ps

interface s16_cpu_bus_if import s16_main_pkg::*; ();

    // Held stable by the master while req is high
    logic              req;
    logic              rnw;
    s16_addr_t         addr;
    logic              uds;
    logic              lds;
    logic [DATA_W-1:0] wdata;
    // Interrupt acknowledge cycle
    logic              iack;

    modport decode (
        input req,
        input addr
    );

    modport io (
        input req,
        input rnw,
        input addr,
        input lds,
        input wdata
    );

    modport ack (
        input req,
        input iack
    );

endinterface

// File: hw/s16_mem_map.sv
`timescale 1ns/1ps

module s16_mem_map import s16_main_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    s16_cpu_bus_if.decode     bus,
    input  logic              rom_ok,
    input  logic              ram_ok,
    input  logic [DATA_W-1:0] rom_data,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [DATA_W-1:0] char_dout,
    input  logic [DATA_W-1:0] pal_dout,
    input  logic [DATA_W-1:0] obj_dout,
    input  logic [BYTE_W-1:0] cab_dout,
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              char_cs,
    output logic              pal_cs,
    output logic              obj_cs,
    output logic              io_cs,
    output logic              sel_valid,
    output logic              sel_wait,
    output logic [DATA_W-1:0] bus_din
);

    logic       req_q;
    logic       decode_en;
    logic [1:0] area;
    logic [2:0] page;

    assign area = bus.addr.region.area;
    assign page = bus.addr.region.page;

    // Second edge of a held request
    assign decode_en = bus.req && req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q     <= 1'b0;
            sel_valid <= 1'b0;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            obj_cs    <= 1'b0;
            io_cs     <= 1'b0;
        end else begin
            req_q     <= bus.req;
            // Unmapped cycles still get sel_valid but no select
            sel_valid <= decode_en;
            rom_cs    <= decode_en && area == AREA_ROM;
            vram_cs   <= decode_en && area == AREA_VID && page == PAGE_VRAM;
            char_cs   <= decode_en && area == AREA_VID && page == PAGE_CHAR;
            obj_cs    <= decode_en && area == AREA_VID && page == PAGE_OBJ;
            pal_cs    <= decode_en && area == AREA_PAL && page == PAGE_PAL;
            io_cs     <= decode_en && area == AREA_SYS && page == PAGE_IO;
            ram_cs    <= decode_en && area == AREA_SYS && page == PAGE_RAM;
        end
    end

    // External memories hold the cycle until their ok
    assign sel_wait = (rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok);

    always_ff @(posedge clk) begin
        if (rom_cs) begin
            bus_din <= rom_data;
        end else if (ram_cs || vram_cs) begin
            bus_din <= ram_data;
        end else if (char_cs) begin
            bus_din <= char_dout;
        end else if (pal_cs) begin
            bus_din <= pal_dout;
        end else if (obj_cs) begin
            bus_din <= obj_dout;
        end else if (io_cs) begin
            bus_din <= {{BYTE_W{1'b1}}, cab_dout};
        end else begin
            bus_din <= '1;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs, io_cs}));

endmodule

// File: hw/s16_dtack.sv
`timescale 1ns/1ps

module s16_dtack (
    input  logic       clk,
    input  logic       rst,
    s16_cpu_bus_if.ack bus,
    input  logic       sel_valid,
    input  logic       sel_wait,
    output logic       bus_ack
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WAIT  = 2'd1;
    localparam logic [1:0] ST_ACKED = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            bus_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus.req) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Master gave up early
                    if (!bus.req) begin
                        state <= ST_IDLE;
                    end else if (sel_valid && !sel_wait) begin
                        state   <= ST_ACKED;
                        bus_ack <= 1'b1;
                    end
                end
                ST_ACKED: begin
                    if (!bus.req) begin
                        state   <= ST_IDLE;
                        bus_ack <= 1'b0;
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    bus_ack <= 1'b0;
                end
            endcase
        end
    end

    a_ack_late: assert property (@(posedge clk) disable iff (rst)
        bus_ack |-> $past(bus.req, 2));

    a_ack_hold: assert property (@(posedge clk) disable iff (rst)
        bus_ack && bus.req |=> bus_ack);

endmodule

// File: hw/s16_cab_io.sv
`timescale 1ns/1ps

module s16_cab_io import s16_main_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    s16_cpu_bus_if.io         bus,
    input  logic              io_cs,
    input  logic [BYTE_W-1:0] joystick1,
    input  logic [BYTE_W-1:0] joystick2,
    input  logic [BYTE_W-1:0] dipsw_a,
    input  logic [BYTE_W-1:0] dipsw_b,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic              snd_ack,
    output logic [BYTE_W-1:0] cab_dout,
    output logic [BYTE_W-1:0] snd_latch,
    output logic              flip,
    output logic              snd_irq_n
);

    logic [BYTE_W-1:0] port_a;
    logic [BYTE_W-1:0] port_b;
    logic [BYTE_W-1:0] port_c;
    logic [BYTE_W-1:0] rd_val;
    logic              io_cs_q;
    logic              ppi_wr;
    logic [1:0]        io_port;
    logic [1:0]        io_reg;

    // Board wiring of the joystick lines
    function automatic logic [BYTE_W-1:0] sort_joy(input logic [BYTE_W-1:0] joy);
        sort_joy = {joy[1], joy[0], joy[3], joy[2], joy[7], joy[5], joy[4], joy[6]};
    endfunction

    assign io_port = bus.addr.io.io_port;
    assign io_reg  = bus.addr.io.io_reg;

    always_comb begin
        rd_val = '1;
        case (io_port)
            IO_PPI: begin
                case (io_reg)
                    2'd0: rd_val = port_a;
                    2'd1: rd_val = port_b;
                    // Sound CPU handshake comes back on PC6
                    2'd2: rd_val = {port_c[7], snd_ack, port_c[5:0]};
                    default: rd_val = '1;
                endcase
            end
            IO_CAB: begin
                case (io_reg)
                    2'd0: rd_val = {2'b11, start_button, service, 1'b1, coin_input};
                    2'd1: rd_val = sort_joy(joystick1);
                    2'd3: rd_val = sort_joy(joystick2);
                    default: rd_val = '1;
                endcase
            end
            IO_DIP: rd_val = io_reg[0] ? dipsw_b : dipsw_a;
            default: rd_val = '1;
        endcase
    end

    // One load per cycle, on the first edge with the select up
    assign ppi_wr = io_cs && !io_cs_q && !bus.rnw && bus.lds && io_port == IO_PPI;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_cs_q  <= 1'b0;
            cab_dout <= '1;
            port_a   <= '1;
            port_b   <= '0;
            port_c   <= '1;
        end else begin
            io_cs_q <= io_cs;
            if (bus.req) begin
                cab_dout <= rd_val;
            end
            if (ppi_wr) begin
                case (io_reg)
                    2'd0: port_a <= bus.wdata[BYTE_W-1:0];
                    2'd1: port_b <= bus.wdata[BYTE_W-1:0];
                    2'd2: port_c <= bus.wdata[BYTE_W-1:0];
                    // Control word, only mode 0 is supported
                    default: ;
                endcase
            end
        end
    end

    assign snd_latch = port_a;
    assign flip      = port_b[7];
    assign snd_irq_n = port_c[7];

endmodule

// File: hw/s16_vblank_irq.sv
`timescale 1ns/1ps

module s16_vblank_irq #(
    parameter int IRQ_LINE = 223
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vdump,
    input  logic       hstart,
    s16_cpu_bus_if.ack bus,
    output logic       irq
);

    logic hstart_q;
    logic line_start;

    // Start of the interrupt line only
    assign line_start = hstart && !hstart_q && vdump == 9'(IRQ_LINE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hstart_q <= 1'b0;
            irq      <= 1'b0;
        end else begin
            hstart_q <= hstart;
            // Acknowledge wins over a new request
            if (bus.req && bus.iack) begin
                irq <= 1'b0;
            end else if (line_start) begin
                irq <= 1'b1;
            end
        end
    end

endmodule

// File: hw/s16_main.sv
`timescale 1ns/1ps

module s16_main import s16_main_pkg::*; #(
    parameter int IRQ_LINE = 223
) (
    input  logic              clk,
    input  logic              rst,
    // CPU bus
    input  logic              bus_req,
    input  logic              bus_rnw,
    input  logic              bus_uds,
    input  logic              bus_lds,
    input  logic              bus_iack,
    input  logic [23:1]       bus_addr,
    input  logic [DATA_W-1:0] bus_dout,
    output logic [DATA_W-1:0] bus_din,
    output logic              bus_ack,
    // Memory and video selects
    output logic              rom_cs,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              char_cs,
    output logic              pal_cs,
    output logic              obj_cs,
    output logic              io_cs,
    input  logic              rom_ok,
    input  logic              ram_ok,
    input  logic [DATA_W-1:0] rom_data,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [DATA_W-1:0] char_dout,
    input  logic [DATA_W-1:0] pal_dout,
    input  logic [DATA_W-1:0] obj_dout,
    output logic [17:1]       rom_addr,
    output logic [12:1]       cpu_addr,
    output logic              uds_wn,
    output logic              lds_wn,
    // Cabinet and sound
    input  logic [BYTE_W-1:0] joystick1,
    input  logic [BYTE_W-1:0] joystick2,
    input  logic [BYTE_W-1:0] dipsw_a,
    input  logic [BYTE_W-1:0] dipsw_b,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic              snd_ack,
    output logic [BYTE_W-1:0] snd_latch,
    output logic              flip,
    output logic              snd_irq_n,
    // Video timing
    input  logic [8:0]        vdump,
    input  logic              hstart,
    output logic              irq
);

    logic [BYTE_W-1:0] cab_dout;
    logic              sel_valid;
    logic              sel_wait;

    s16_cpu_bus_if bus ();

    assign bus.req   = bus_req;
    assign bus.rnw   = bus_rnw;
    assign bus.addr  = bus_addr;
    assign bus.uds   = bus_uds;
    assign bus.lds   = bus_lds;
    assign bus.wdata = bus_dout;
    assign bus.iack  = bus_iack;

    assign rom_addr = bus_addr[17:1];
    assign cpu_addr = bus_addr[12:1];

    // Active-low byte write strobes
    assign uds_wn = bus.rnw | ~bus.uds;
    assign lds_wn = bus.rnw | ~bus.lds;

    s16_mem_map u_mem_map (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.decode),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .obj_cs    (obj_cs),
        .io_cs     (io_cs),
        .sel_valid (sel_valid),
        .sel_wait  (sel_wait),
        .bus_din   (bus_din)
    );

    s16_dtack u_dtack (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.ack),
        .sel_valid (sel_valid),
        .sel_wait  (sel_wait),
        .bus_ack   (bus_ack)
    );

    s16_cab_io u_cab_io (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus.io),
        .io_cs        (io_cs),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .snd_ack      (snd_ack),
        .cab_dout     (cab_dout),
        .snd_latch    (snd_latch),
        .flip         (flip),
        .snd_irq_n    (snd_irq_n)
    );

    s16_vblank_irq #(
        .IRQ_LINE (IRQ_LINE)
    ) u_vblank_irq (
        .clk    (clk),
        .rst    (rst),
        .vdump  (vdump),
        .hstart (hstart),
        .bus    (bus.ack),
        .irq    (irq)
    );

endmodule

// File: verification/s16_main_tb.sv
`timescale 1ns/1ps

module s16_main_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_EDGES  = 4;
    localparam int IRQ_LINE     = 223;
    localparam int ACK_LIMIT    = 32;
    // Watchdog budget in clock edges
    localparam int BUS_OPS      = 60;
    localparam int OP_EDGES     = 12;
    localparam int VBLANK_EDGES = 40;
    localparam int MARGIN_EDGES = 200;
    localparam int WATCHDOG_NS  = CLK_PERIOD *
        (RESET_EDGES + BUS_OPS * OP_EDGES + VBLANK_EDGES + MARGIN_EDGES);

    // Select order rom, ram, vram, char, pal, obj, io
    localparam logic [6:0] SEL_NONE = 7'b0000000;
    localparam logic [6:0] SEL_ROM  = 7'b1000000;
    localparam logic [6:0] SEL_RAM  = 7'b0100000;
    localparam logic [6:0] SEL_VRAM = 7'b0010000;
    localparam logic [6:0] SEL_CHAR = 7'b0001000;
    localparam logic [6:0] SEL_PAL  = 7'b0000100;
    localparam logic [6:0] SEL_OBJ  = 7'b0000010;
    localparam logic [6:0] SEL_IO   = 7'b0000001;

    localparam logic [15:0] ROM_KEY  = 16'hA5C3;
    localparam logic [15:0] RAM_KEY  = 16'h3C5A;
    localparam logic [15:0] CHAR_KEY = 16'h0F0F;
    localparam logic [15:0] PAL_KEY  = 16'h1248;
    localparam logic [15:0] OBJ_KEY  = 16'h7E81;

    // Joystick source bit per output bit, high to low
    localparam logic [23:0] JOY_SRC = {3'd1, 3'd0, 3'd3, 3'd2, 3'd7, 3'd5, 3'd4, 3'd6};

    logic        clk;
    logic        rst;
    logic        bus_req;
    logic        bus_rnw;
    logic        bus_uds;
    logic        bus_lds;
    logic        bus_iack;
    logic [23:1] bus_addr;
    logic [15:0] bus_dout;
    logic [15:0] bus_din;
    logic        bus_ack;
    logic        rom_cs;
    logic        ram_cs;
    logic        vram_cs;
    logic        char_cs;
    logic        pal_cs;
    logic        obj_cs;
    logic        io_cs;
    logic        rom_ok;
    logic        ram_ok;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [17:1] rom_addr;
    logic [12:1] cpu_addr;
    logic        uds_wn;
    logic        lds_wn;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        snd_ack;
    logic [7:0]  snd_latch;
    logic        flip;
    logic        snd_irq_n;
    logic [8:0]  vdump;
    logic        hstart;
    logic        irq;

    logic [6:0]  sel_vec;
    logic [15:0] exp_din;
    logic [6:0]  exp_sel;
    logic        check_rd;
    logic [23:0] cur_addr;
    // Upper and lower data strobes for the next cycle
    logic [1:0]  cycle_strobes;
    integer      seed;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;
    string       test_name;

    s16_main #(
        .IRQ_LINE (IRQ_LINE)
    ) u_s16_main (.*);

    // Memory model word pattern that folds in every address bit
    function automatic logic [15:0] expected_word(input logic [23:0] addr,
                                                  input logic [15:0] key);
        expected_word = addr[16:1] ^ {9'd0, addr[23:17]} ^ key;
    endfunction

    function automatic logic [7:0] wire_joystick(input logic [7:0] joy);
        logic [7:0] res;
        for (int i = 0; i < 8; i++) begin
            res[i] = joy[JOY_SRC[3*i +: 3]];
        end
        wire_joystick = res;
    endfunction

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    // Memory models
    assign rom_data  = expected_word({bus_addr, 1'b0}, ROM_KEY);
    assign ram_data  = expected_word({bus_addr, 1'b0}, RAM_KEY);
    assign char_dout = expected_word({bus_addr, 1'b0}, CHAR_KEY);
    assign pal_dout  = expected_word({bus_addr, 1'b0}, PAL_KEY);
    assign obj_dout  = expected_word({bus_addr, 1'b0}, OBJ_KEY);

    assign sel_vec = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs, io_cs};

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic log_failure(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic expect_equal(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got === exp) else log_mismatch(name, got, exp);
    endtask

    task automatic next_edges(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Four-phase cycle entered and left 1 ns after a rising edge
    task automatic bus_cycle(input logic [23:0] addr, input logic rnw,
                             input logic [15:0] wdata, input logic iack);
        int edges;
        cur_addr = addr;
        bus_addr = addr[23:1];
        bus_rnw  = rnw;
        bus_dout = wdata;
        bus_iack = iack;
        bus_uds  = cycle_strobes[1];
        bus_lds  = cycle_strobes[0];
        bus_req  = 1'b1;
        edges    = 0;
        do begin
            next_edges(1);
            edges++;
        end while (!bus_ack && edges < ACK_LIMIT);
        if (!bus_ack) begin
            log_failure($sformatf("no acknowledge for address %h", addr));
        end
        bus_req = 1'b0;
        edges   = 0;
        while (bus_ack && edges < ACK_LIMIT) begin
            next_edges(1);
            edges++;
        end
        if (bus_ack) begin
            log_failure($sformatf("acknowledge stuck high after address %h", addr));
        end
        bus_rnw  = 1'b1;
        bus_iack = 1'b0;
        bus_uds  = 1'b0;
        bus_lds  = 1'b0;
    endtask

    task automatic read_expect(input logic [23:0] addr, input logic [6:0] sel,
                               input logic [15:0] data);
        exp_sel  = sel;
        exp_din  = data;
        check_rd = 1'b1;
        bus_cycle(addr, 1'b1, 16'h0000, 1'b0);
    endtask

    task automatic write_expect(input logic [23:0] addr, input logic [6:0] sel,
                                input logic [15:0] data);
        exp_sel  = sel;
        check_rd = 1'b0;
        bus_cycle(addr, 1'b0, data, 1'b0);
    endtask

    task automatic iack_cycle();
        exp_sel  = SEL_NONE;
        exp_din  = 16'hFFFF;
        check_rd = 1'b1;
        bus_cycle(24'hC00000, 1'b1, 16'h0000, 1'b1);
    endtask

    task automatic hstart_pulse(input logic [8:0] line);
        vdump  = line;
        hstart = 1'b1;
        next_edges(3);
        hstart = 1'b0;
        next_edges(2);
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = error_count;
    endtask

    task automatic end_test();
        // Let the last cycle's checks complete
        next_edges(2);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, test_name,
                     error_count - test_start_errors);
        end
    endtask

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        bus_ack && check_rd |-> bus_din == exp_din)
        else log_mismatch("bus_din", $sampled(bus_din), $sampled(exp_din));

    a_select: assert property (@(posedge clk) disable iff (rst)
        bus_ack |-> sel_vec == exp_sel)
        else log_mismatch("chip selects", {9'd0, $sampled(sel_vec)}, {9'd0, $sampled(exp_sel)});

    a_rom_addr: assert property (@(posedge clk) disable iff (rst)
        bus_req |-> rom_addr == cur_addr[17:1])
        else log_mismatch("rom_addr", $sampled(rom_addr), $sampled(cur_addr[17:1]));

    a_cpu_addr: assert property (@(posedge clk) disable iff (rst)
        bus_req |-> cpu_addr == cur_addr[12:1])
        else log_mismatch("cpu_addr", $sampled(cpu_addr), $sampled(cur_addr[12:1]));

    a_read_strobes: assert property (@(posedge clk) disable iff (rst)
        bus_req && bus_rnw |-> uds_wn && lds_wn)
        else log_failure("a write strobe was low during a read cycle");

    // Active-low strobe per byte lane that the master enables
    a_write_strobes: assert property (@(posedge clk) disable iff (rst)
        bus_req && !bus_rnw |-> uds_wn == !bus_uds && lds_wn == !bus_lds)
        else log_failure("write strobes did not follow uds and lds in a write cycle");

    a_rom_ready: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) && rom_cs |-> $past(rom_ok))
        else log_failure("bus_ack rose before rom_ok");

    a_ram_ready: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) && (ram_cs || vram_cs) |-> $past(ram_ok))
        else log_failure("bus_ack rose before ram_ok");

    // Request first sampled three samples back means edge 2 or later
    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) |-> $past(bus_req, 3))
        else log_failure("bus_ack came before edge 2 of the cycle");

    a_ack_release: assert property (@(posedge clk) disable iff (rst)
        $fell(bus_req) |=> !bus_ack && $past(bus_ack))
        else log_failure("bus_ack did not fall one edge after bus_req");

    a_irq_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(irq) |-> $past(hstart, 1) && !$past(hstart, 2) &&
            $past(vdump, 1) == 9'(IRQ_LINE))
        else log_failure("irq rose without a rising hstart on the interrupt line");

    a_irq_clear: assert property (@(posedge clk) disable iff (rst)
        bus_req && bus_iack |=> !irq)
        else log_failure("irq still high after an acknowledge cycle");

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    // ROM and RAM ready after a random number of edges
    initial begin : ok_driver
        int rom_left;
        int ram_left;
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        rom_left = 0;
        ram_left = 0;
        forever begin
            next_edges(1);
            if (rom_cs) begin
                if (rom_left > 0) begin
                    rom_left--;
                end
                rom_ok = (rom_left == 0);
            end else begin
                rom_left = {$random(seed)} % 5;
                rom_ok   = 1'b0;
            end
            if (ram_cs || vram_cs) begin
                if (ram_left > 0) begin
                    ram_left--;
                end
                ram_ok = (ram_left == 0);
            end else begin
                ram_left = {$random(seed)} % 5;
                ram_ok   = 1'b0;
            end
        end
    end

    task automatic check_reset();
        begin_test("reset values");
        expect_equal("chip selects", {9'd0, sel_vec}, 16'h0000);
        expect_equal("bus_ack", {15'd0, bus_ack}, 16'h0000);
        expect_equal("irq", {15'd0, irq}, 16'h0000);
        expect_equal("snd_latch", {8'h00, snd_latch}, 16'h00FF);
        expect_equal("snd_irq_n", {15'd0, snd_irq_n}, 16'h0001);
        expect_equal("flip", {15'd0, flip}, 16'h0000);
        end_test();
    endtask

    task automatic read_memory_map();
        begin_test("memory map");
        read_expect(24'h001234, SEL_ROM, expected_word(24'h001234, ROM_KEY));
        read_expect(24'h400100, SEL_VRAM, expected_word(24'h400100, RAM_KEY));
        read_expect(24'h410200, SEL_CHAR, expected_word(24'h410200, CHAR_KEY));
        read_expect(24'h440010, SEL_OBJ, expected_word(24'h440010, OBJ_KEY));
        read_expect(24'h840020, SEL_PAL, expected_word(24'h840020, PAL_KEY));
        read_expect(24'hFF0040, SEL_RAM, expected_word(24'hFF0040, RAM_KEY));
        write_expect(24'hFF0100, SEL_RAM, 16'h1234);
        // Unmapped, then the old watchdog region
        read_expect(24'h420000, SEL_NONE, 16'hFFFF);
        read_expect(24'h800000, SEL_NONE, 16'hFFFF);
        read_expect(24'hC00000, SEL_NONE, 16'hFFFF);
        read_expect(24'hC60000, SEL_NONE, 16'hFFFF);
        end_test();
    endtask

    task automatic read_with_waits();
        logic [31:0] r;
        logic [23:0] addr;
        begin_test("wait states");
        for (int i = 0; i < 8; i++) begin
            r    = next_random();
            addr = {2'b00, r[21:1], 1'b0};
            read_expect(addr, SEL_ROM, expected_word(addr, ROM_KEY));
            r    = next_random();
            addr = {2'b11, r[21:19], 3'd7, r[15:1], 1'b0};
            read_expect(addr, SEL_RAM, expected_word(addr, RAM_KEY));
            r    = next_random();
            addr = {2'b01, r[21:19], 3'd0, r[15:1], 1'b0};
            read_expect(addr, SEL_VRAM, expected_word(addr, RAM_KEY));
        end
        end_test();
    endtask

    task automatic read_cabinet();
        logic [31:0] r;
        begin_test("cabinet reads");
        r            = next_random();
        joystick1    = r[7:0];
        joystick2    = r[15:8];
        dipsw_a      = r[23:16];
        r            = next_random();
        dipsw_b      = r[7:0];
        start_button = r[9:8];
        coin_input   = r[11:10];
        service      = r[12];
        read_expect(24'hC41000, SEL_IO,
                    {8'hFF, 2'b11, start_button, service, 1'b1, coin_input});
        read_expect(24'hC41002, SEL_IO, {8'hFF, wire_joystick(joystick1)});
        read_expect(24'hC41006, SEL_IO, {8'hFF, wire_joystick(joystick2)});
        read_expect(24'hC41004, SEL_IO, 16'hFFFF);
        read_expect(24'hC42000, SEL_IO, {8'hFF, dipsw_a});
        read_expect(24'hC42002, SEL_IO, {8'hFF, dipsw_b});
        read_expect(24'hC43000, SEL_IO, 16'hFFFF);
        end_test();
    endtask

    task automatic drive_ppi();
        begin_test("ppi ports");
        write_expect(24'hC40000, SEL_IO, 16'h005A);
        expect_equal("snd_latch", {8'h00, snd_latch}, 16'h005A);
        // Upper byte only leaves the PPI ports alone
        cycle_strobes = 2'b10;
        write_expect(24'hC40000, SEL_IO, 16'hA5A5);
        cycle_strobes = 2'b11;
        expect_equal("snd_latch", {8'h00, snd_latch}, 16'h005A);
        write_expect(24'hC40002, SEL_IO, 16'h0080);
        expect_equal("flip", {15'd0, flip}, 16'h0001);
        write_expect(24'hC40004, SEL_IO, 16'h003F);
        expect_equal("snd_irq_n", {15'd0, snd_irq_n}, 16'h0000);
        // PC6 comes from the sound CPU, not the register
        snd_ack = 1'b1;
        read_expect(24'hC40004, SEL_IO, {8'hFF, 1'b0, 1'b1, 6'h3F});
        read_expect(24'hC40000, SEL_IO, 16'hFF5A);
        read_expect(24'hC40002, SEL_IO, 16'hFF80);
        write_expect(24'hC40004, SEL_IO, 16'h0080);
        expect_equal("snd_irq_n", {15'd0, snd_irq_n}, 16'h0001);
        snd_ack = 1'b0;
        read_expect(24'hC40004, SEL_IO, 16'hFF80);
        write_expect(24'hC40002, SEL_IO, 16'h0000);
        expect_equal("flip", {15'd0, flip}, 16'h0000);
        end_test();
    endtask

    task automatic raise_vblank();
        begin_test("vblank irq");
        hstart_pulse(9'd100);
        expect_equal("irq", {15'd0, irq}, 16'h0000);
        // Line changes to the irq line with hstart already high
        vdump  = 9'(IRQ_LINE - 1);
        hstart = 1'b1;
        next_edges(2);
        vdump = 9'(IRQ_LINE);
        next_edges(2);
        hstart = 1'b0;
        next_edges(2);
        expect_equal("irq", {15'd0, irq}, 16'h0000);
        hstart_pulse(9'(IRQ_LINE));
        expect_equal("irq", {15'd0, irq}, 16'h0001);
        iack_cycle();
        expect_equal("irq", {15'd0, irq}, 16'h0000);
        end_test();
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed          = 32806;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rst           = 1'b1;
        bus_req       = 1'b0;
        bus_rnw       = 1'b1;
        bus_uds       = 1'b0;
        bus_lds       = 1'b0;
        bus_iack      = 1'b0;
        bus_addr      = '0;
        bus_dout      = '0;
        joystick1     = 8'hFF;
        joystick2     = 8'hFF;
        dipsw_a       = 8'hFF;
        dipsw_b       = 8'hFF;
        start_button  = 2'b11;
        coin_input    = 2'b11;
        service       = 1'b1;
        snd_ack       = 1'b0;
        vdump         = '0;
        hstart        = 1'b0;
        exp_din       = 16'hFFFF;
        exp_sel       = SEL_NONE;
        check_rd      = 1'b0;
        cur_addr      = '0;
        cycle_strobes = 2'b11;
        repeat (RESET_EDGES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset();
        read_memory_map();
        read_with_waits();
        read_cabinet();
        drive_ppi();
        raise_vblank();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: files.f
hw/s16_main_pkg.sv
hw/s16_cpu_bus_if.sv
hw/s16_mem_map.sv
hw/s16_dtack.sv
hw/s16_cab_io.sv
hw/s16_vblank_irq.sv
hw/s16_main.sv
verification/s16_main_tb.sv

// File: Makefile
# Verilator simulation of the main-CPU glue

VERILATOR ?= verilator
TOP       ?= s16_main_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hw/*.sv verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
